//--- design/chroma_upsampler.sv
`timescale 1ns/1ps
`default_nettype none

module chroma_upsampler import yuv2rgb_pkg::*; (
	input  logic         Clock,
	input  logic         resetn,
	input  logic         load,
	input  logic [7:0]   sample,
	output chroma_pair_t chroma
);

	// [5] is c[k-2] ... [0] is c[k+3]
	logic [5:0][7:0]    win;
	logic [5:0][7:0]    next_win;
	logic signed [31:0] sum_far;
	logic signed [31:0] sum_mid;
	logic signed [31:0] sum_near;
	logic signed [31:0] acc;

	assign next_win = {win[4:0], sample};

	always_comb begin
		sum_far  = 32'(next_win[5]) + 32'(next_win[0]);
		sum_mid  = 32'(next_win[4]) + 32'(next_win[1]);
		sum_near = 32'(next_win[3]) + 32'(next_win[2]);
		acc = TAP_FAR * sum_far + TAP_MID * sum_mid + TAP_NEAR * sum_near + 32'sd128; // rounding
	end

	always_ff @(posedge Clock) begin
		if (load)
			win <= next_win;
	end

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			chroma <= '0;
		end else if (load) begin
			chroma <= '{even: next_win[3], odd: clip_u8(acc >>> 8)};
		end
	end

endmodule

`default_nettype wire

//--- design/colour_matrix.sv
`timescale 1ns/1ps
`default_nettype none

module colour_matrix import yuv2rgb_pkg::*; (
	input  logic      Clock,
	input  logic      resetn,
	input  logic      pair_valid,
	input  yuv_pair_t pair,
	output rgb_pair_t rgb,
	output logic      rgb_valid
);

	logic [1:0][7:0] y_in;
	logic [1:0][7:0] u_in;
	logic [1:0][7:0] v_in;

	logic signed [31:0] y_term [2];
	logic signed [31:0] rv_term [2];
	logic signed [31:0] gu_term [2];
	logic signed [31:0] gv_term [2];
	logic signed [31:0] bu_term [2];

	logic signed [31:0] r_sum [2];
	logic signed [31:0] g_sum [2];
	logic signed [31:0] b_sum [2];

	logic stage1_valid;

	function automatic logic signed [31:0] centred(input logic [7:0] x, input int offset);
		return $signed(32'(x)) - offset;
	endfunction

	assign y_in = {pair.y_odd, pair.y_even}; // index 0 is the even pixel
	assign u_in = {pair.u.odd, pair.u.even};
	assign v_in = {pair.v.odd, pair.v.even};

	always_ff @(posedge Clock) begin
		if (pair_valid) begin
			for (int p = 0; p < 2; p++) begin
				y_term[p]  <= COEF_Y * centred(y_in[p], Y_OFFSET);
				rv_term[p] <= COEF_RV * centred(v_in[p], C_OFFSET);
				gu_term[p] <= COEF_GU * centred(u_in[p], C_OFFSET);
				gv_term[p] <= COEF_GV * centred(v_in[p], C_OFFSET);
				bu_term[p] <= COEF_BU * centred(u_in[p], C_OFFSET);
			end
		end
	end

	always_comb begin
		for (int p = 0; p < 2; p++) begin
			r_sum[p] = (y_term[p] + rv_term[p]) >>> 16;
			g_sum[p] = (y_term[p] + gu_term[p] + gv_term[p]) >>> 16;
			b_sum[p] = (y_term[p] + bu_term[p]) >>> 16;
		end
	end

	always_ff @(posedge Clock) begin
		if (stage1_valid) begin // held until the next pair
			rgb <= '{
				r0: clip_u8(r_sum[0]),
				g0: clip_u8(g_sum[0]),
				b0: clip_u8(b_sum[0]),
				r1: clip_u8(r_sum[1]),
				g1: clip_u8(g_sum[1]),
				b1: clip_u8(b_sum[1])
			};
		end
	end

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			stage1_valid <= 1'b0;
			rgb_valid <= 1'b0;
		end else begin
			stage1_valid <= pair_valid;
			rgb_valid <= stage1_valid;
		end
	end

endmodule

`default_nettype wire

//--- design/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer import yuv2rgb_pkg::*; #(
	parameter int IMG_WIDTH  = 320,
	parameter int IMG_HEIGHT = 240,
	parameter int RGB_BASE   = 146944
) (
	input  logic              Clock,
	input  logic              resetn,
	input  logic              start,
	input  logic [DATA_W-1:0] read_data,
	input  chroma_pair_t      u_chroma,
	input  chroma_pair_t      v_chroma,
	input  rgb_pair_t         rgb,
	input  logic              rgb_valid,
	output logic              u_load,
	output logic              v_load,
	output logic [7:0]        u_sample,
	output logic [7:0]        v_sample,
	output yuv_pair_t         pair,
	output logic              pair_valid,
	output sram_req_t         sram,
	output logic              done
);

	localparam logic [ADDR_W-1:0] Y_BASE    = '0;
	localparam logic [ADDR_W-1:0] U_BASE    = ADDR_W'(IMG_WIDTH * IMG_HEIGHT / 2);
	localparam logic [ADDR_W-1:0] V_BASE    = U_BASE + ADDR_W'(IMG_WIDTH * IMG_HEIGHT / 4);
	localparam logic [ADDR_W-1:0] RGB_START = ADDR_W'(RGB_BASE);

	localparam int PAIR_W = $clog2(IMG_WIDTH);
	localparam int ROW_W  = $clog2(IMG_HEIGHT + 1);
	localparam logic [PAIR_W-1:0] LAST_PAIR = PAIR_W'(IMG_WIDTH / 2 - 1);
	localparam logic [ROW_W-1:0]  LAST_ROW  = ROW_W'(IMG_HEIGHT - 1);

	// read tags, one per outstanding read slot
	localparam logic [2:0] TAG_Y = 3'b100;
	localparam logic [2:0] TAG_U = 3'b010;
	localparam logic [2:0] TAG_V = 3'b001;

	seq_state_t        state;
	logic [3:0]        step;
	logic [ROW_W-1:0]  row_cnt;
	logic [PAIR_W-1:0] pair_cnt;
	logic [ADDR_W-1:0] y_cnt;
	logic [ADDR_W-1:0] u_cnt;
	logic [ADDR_W-1:0] v_cnt;
	logic [ADDR_W-1:0] rgb_cnt;

	logic [READ_LATENCY:0][2:0] rd_pipe;
	logic                       rd_busy;

	logic [DATA_W-1:0]      y_word;
	logic [1:0][DATA_W-1:0] u_word; // [1] is the newest word
	logic [1:0][DATA_W-1:0] v_word;

	logic [PAIR_W-1:0] ahead_idx;
	logic              ahead_hi;
	logic              fetch_chroma;

	// row start order c0 c0 c0 c1 c2 c3
	function automatic logic [7:0] lead_sample(input logic [1:0][DATA_W-1:0] w,
			input logic [3:0] idx);
		case (idx)
		4'd3: return w[0][7:0];
		4'd4: return w[1][15:8];
		4'd5: return w[1][7:0];
		default: return w[0][15:8];
		endcase
	endfunction

	assign ahead_idx    = pair_cnt + PAIR_W'(3);
	assign ahead_hi     = (ahead_idx <= LAST_PAIR) && !ahead_idx[0]; // even index, new word
	assign fetch_chroma = (pair_cnt != '0) && ahead_hi;
	assign rd_busy      = |rd_pipe;

	assign pair = '{y_even: y_word[15:8], y_odd: y_word[7:0], u: u_chroma, v: v_chroma};

	always_ff @(posedge Clock) begin
		if (rd_pipe[READ_LATENCY] == TAG_Y)
			y_word <= read_data;
		if (rd_pipe[READ_LATENCY] == TAG_U)
			u_word <= {read_data, u_word[1]};
		if (rd_pipe[READ_LATENCY] == TAG_V)
			v_word <= {read_data, v_word[1]};
	end

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			state <= IDLE;
			step <= '0;
			row_cnt <= '0;
			pair_cnt <= '0;
			y_cnt <= Y_BASE;
			u_cnt <= U_BASE;
			v_cnt <= V_BASE;
			rgb_cnt <= RGB_START;
			rd_pipe <= '0;
			sram <= '{addr: '0, wdata: '0, we_n: 1'b1};
			u_load <= 1'b0;
			v_load <= 1'b0;
			u_sample <= '0;
			v_sample <= '0;
			pair_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			sram.we_n <= 1'b1;
			u_load <= 1'b0;
			v_load <= 1'b0;
			pair_valid <= 1'b0;
			done <= 1'b0;
			rd_pipe <= {rd_pipe[READ_LATENCY-1:0], 3'b000};

			case (state)
			IDLE: begin
				if (start) begin
					step <= '0;
					row_cnt <= '0;
					pair_cnt <= '0;
					y_cnt <= Y_BASE;
					u_cnt <= U_BASE;
					v_cnt <= V_BASE;
					rgb_cnt <= RGB_START;
					state <= ROW_LOAD;
				end
			end

			ROW_LOAD: begin
				if (step < 4'd4) begin
					if (!step[0]) begin // u0u1 then u2u3
						sram.addr <= u_cnt;
						u_cnt <= u_cnt + 1'b1;
						rd_pipe[0] <= TAG_U;
					end else begin
						sram.addr <= v_cnt;
						v_cnt <= v_cnt + 1'b1;
						rd_pipe[0] <= TAG_V;
					end
					step <= step + 1'b1;
				end else if (step == 4'd4) begin
					if (!rd_busy)
						step <= 4'd5;
				end else begin
					u_load <= 1'b1;
					v_load <= 1'b1;
					u_sample <= lead_sample(u_word, step - 4'd5);
					v_sample <= lead_sample(v_word, step - 4'd5);
					if (step == 4'd10) begin
						step <= '0;
						state <= PAIR_FETCH;
					end else begin
						step <= step + 1'b1;
					end
				end
			end

			PAIR_FETCH: begin
				case (step)
				4'd0: begin
					sram.addr <= y_cnt;
					y_cnt <= y_cnt + 1'b1;
					rd_pipe[0] <= TAG_Y;
					step <= 4'd1;
				end
				4'd1: begin
					if (fetch_chroma) begin
						sram.addr <= u_cnt;
						u_cnt <= u_cnt + 1'b1;
						rd_pipe[0] <= TAG_U;
					end
					step <= 4'd2;
				end
				4'd2: begin
					if (fetch_chroma) begin
						sram.addr <= v_cnt;
						v_cnt <= v_cnt + 1'b1;
						rd_pipe[0] <= TAG_V;
					end
					step <= 4'd3;
				end
				default: begin
					if (!rd_busy) begin
						step <= '0;
						state <= PAIR_ISSUE;
					end
				end
				endcase
			end

			PAIR_ISSUE: begin
				case (step)
				4'd0: begin
					if (pair_cnt != '0) begin // past the row end this repeats the last sample
						u_load <= 1'b1;
						v_load <= 1'b1;
						u_sample <= ahead_hi ? u_word[1][15:8] : u_word[1][7:0];
						v_sample <= ahead_hi ? v_word[1][15:8] : v_word[1][7:0];
					end
					step <= 4'd1;
				end
				4'd1: begin
					pair_valid <= 1'b1; // chroma settles this cycle
					step <= 4'd2;
				end
				default: begin
					if (rgb_valid) begin
						step <= '0;
						state <= WRITE_0;
					end
				end
				endcase
			end

			WRITE_0: begin
				sram <= '{addr: rgb_cnt, wdata: {rgb.r0, rgb.g0}, we_n: 1'b0};
				rgb_cnt <= rgb_cnt + 1'b1;
				state <= WRITE_1;
			end

			WRITE_1: begin
				sram <= '{addr: rgb_cnt, wdata: {rgb.b0, rgb.r1}, we_n: 1'b0};
				rgb_cnt <= rgb_cnt + 1'b1;
				state <= WRITE_2;
			end

			WRITE_2: begin
				sram <= '{addr: rgb_cnt, wdata: {rgb.g1, rgb.b1}, we_n: 1'b0};
				rgb_cnt <= rgb_cnt + 1'b1;
				if (pair_cnt == LAST_PAIR) begin
					state <= ROW_END;
				end else begin
					pair_cnt <= pair_cnt + 1'b1;
					state <= PAIR_FETCH;
				end
			end

			ROW_END: begin
				pair_cnt <= '0;
				step <= '0;
				if (row_cnt == LAST_ROW) begin
					done <= 1'b1; // last write lands this cycle
					state <= IDLE;
				end else begin
					row_cnt <= row_cnt + 1'b1;
					state <= ROW_LOAD;
				end
			end

			default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/yuv2rgb_pkg.sv
`default_nettype none

package yuv2rgb_pkg;

	localparam int ADDR_W       = 18;
	localparam int DATA_W       = 16;
	localparam int READ_LATENCY = 2; // address to read data, in cycles

	localparam int Y_OFFSET = 16;
	localparam int C_OFFSET = 128;

	// colour matrix, 16.16 fixed point
	localparam logic signed [31:0] COEF_Y  = 32'sd76284;
	localparam logic signed [31:0] COEF_RV = 32'sd104595;
	localparam logic signed [31:0] COEF_GU = -32'sd25624;
	localparam logic signed [31:0] COEF_GV = -32'sd53281;
	localparam logic signed [31:0] COEF_BU = 32'sd132251;

	localparam logic signed [31:0] TAP_FAR  = 32'sd21;
	localparam logic signed [31:0] TAP_MID  = -32'sd52;
	localparam logic signed [31:0] TAP_NEAR = 32'sd159;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              we_n;
	} sram_req_t;

	typedef struct packed {
		logic [7:0] even;
		logic [7:0] odd; // interpolated
	} chroma_pair_t;

	typedef struct packed {
		logic [7:0]   y_even;
		logic [7:0]   y_odd;
		chroma_pair_t u;
		chroma_pair_t v;
	} yuv_pair_t;

	typedef struct packed {
		logic [7:0] r0;
		logic [7:0] g0;
		logic [7:0] b0;
		logic [7:0] r1;
		logic [7:0] g1;
		logic [7:0] b1;
	} rgb_pair_t;

	typedef enum logic [2:0] {
		IDLE, ROW_LOAD, PAIR_FETCH, PAIR_ISSUE,
		WRITE_0, WRITE_1, WRITE_2, ROW_END
	} seq_state_t;

	function automatic logic [7:0] clip_u8(input logic signed [31:0] x);
		if (x < 0)
			return 8'd0;
		else if (x > 255)
			return 8'd255;
		else
			return x[7:0];
	endfunction

endpackage

`default_nettype wire

//--- design/yuv2rgb_top.sv
`timescale 1ns/1ps
`default_nettype none

module yuv2rgb_top import yuv2rgb_pkg::*; #(
	parameter int IMG_WIDTH  = 320,
	parameter int IMG_HEIGHT = 240,
	parameter int RGB_BASE   = 146944
) (
	input  logic              Clock,
	input  logic              resetn,
	input  logic              start,
	input  logic [DATA_W-1:0] read_data,
	output sram_req_t         sram,
	output logic              done
);

	logic         u_load;
	logic         v_load;
	logic [7:0]   u_sample;
	logic [7:0]   v_sample;
	chroma_pair_t u_chroma;
	chroma_pair_t v_chroma;
	yuv_pair_t    pair;
	logic         pair_valid;
	rgb_pair_t    rgb;
	logic         rgb_valid;

	frame_sequencer #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT),
		.RGB_BASE   (RGB_BASE)
	) u_seq (
		.Clock      (Clock),
		.resetn     (resetn),
		.start      (start),
		.read_data  (read_data),
		.u_chroma   (u_chroma),
		.v_chroma   (v_chroma),
		.rgb        (rgb),
		.rgb_valid  (rgb_valid),
		.u_load     (u_load),
		.v_load     (v_load),
		.u_sample   (u_sample),
		.v_sample   (v_sample),
		.pair       (pair),
		.pair_valid (pair_valid),
		.sram       (sram),
		.done       (done)
	);

	chroma_upsampler u_up (
		.Clock  (Clock),
		.resetn (resetn),
		.load   (u_load),
		.sample (u_sample),
		.chroma (u_chroma)
	);

	chroma_upsampler v_up (
		.Clock  (Clock),
		.resetn (resetn),
		.load   (v_load),
		.sample (v_sample),
		.chroma (v_chroma)
	);

	colour_matrix u_cm (
		.Clock      (Clock),
		.resetn     (resetn),
		.pair_valid (pair_valid),
		.pair       (pair),
		.rgb        (rgb),
		.rgb_valid  (rgb_valid)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module yuv2rgb_tb -f yuv2rgb.f -o yuv2rgb_sim
./obj_dir/yuv2rgb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation completed successfully" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

//--- testbench/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_model import yuv2rgb_pkg::*; #(
	parameter int WORDS = 512
) (
	input  logic              Clock,
	input  sram_req_t         req,
	output logic [DATA_W-1:0] read_data
);

	localparam int IDX_W = $clog2(WORDS);

	logic [DATA_W-1:0]                    mem [WORDS];
	logic [READ_LATENCY-1:0][DATA_W-1:0] read_pipe; // [0] is the newest read

	initial read_pipe = '0;

	always @(posedge Clock) begin
		if (!req.we_n)
			mem[req.addr[IDX_W-1:0]] <= req.wdata;
		read_pipe[0] <= mem[req.addr[IDX_W-1:0]];
		for (int i = 1; i < READ_LATENCY; i++) begin
			read_pipe[i] <= read_pipe[i-1];
		end
	end

	assign read_data = read_pipe[READ_LATENCY-1]; // two edges after the address

endmodule

`default_nettype wire

//--- testbench/yuv2rgb_sva.sv
`timescale 1ns/1ps
`default_nettype none

module yuv2rgb_sva import yuv2rgb_pkg::*; #(
	parameter int IMG_WIDTH  = 320,
	parameter int IMG_HEIGHT = 240,
	parameter int RGB_BASE   = 146944
) (
	input logic      Clock,
	input logic      resetn,
	input logic      start,
	input sram_req_t sram,
	input logic      done
);

	localparam int RGB_END = RGB_BASE + 3 * (IMG_WIDTH / 2) * IMG_HEIGHT;

	logic seen_start;

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn)
			seen_start <= 1'b0;
		else if (start)
			seen_start <= 1'b1;
	end

	done_single_cycle: assert property (@(posedge Clock) disable iff (!resetn)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	write_in_rgb_region: assert property (@(posedge Clock) disable iff (!resetn)
		!sram.we_n |-> (int'(sram.addr) >= RGB_BASE && int'(sram.addr) < RGB_END))
		else $error("write outside the RGB region at address %0d", sram.addr);

	no_write_before_start: assert property (@(posedge Clock) disable iff (!resetn)
		!seen_start |-> sram.we_n)
		else $error("we_n went low before the first start");

endmodule

bind yuv2rgb_top yuv2rgb_sva #(
	.IMG_WIDTH  (IMG_WIDTH),
	.IMG_HEIGHT (IMG_HEIGHT),
	.RGB_BASE   (RGB_BASE)
) u_sva (
	.Clock  (Clock),
	.resetn (resetn),
	.start  (start),
	.sram   (sram),
	.done   (done)
);

`default_nettype wire

//--- testbench/yuv2rgb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module yuv2rgb_tb import yuv2rgb_pkg::*; ();

	localparam int IMG_WIDTH    = 16;
	localparam int IMG_HEIGHT   = 3;
	localparam int RGB_BASE     = 200;
	localparam int HALF_W       = IMG_WIDTH / 2;
	localparam int U_BASE       = IMG_WIDTH * IMG_HEIGHT / 2;
	localparam int V_BASE       = U_BASE + IMG_WIDTH * IMG_HEIGHT / 4;
	localparam int YUV_WORDS    = IMG_WIDTH * IMG_HEIGHT;
	localparam int RGB_WORDS    = 3 * HALF_W * IMG_HEIGHT;
	localparam int MEM_WORDS    = 512;
	localparam int DONE_TIMEOUT = 5000;

	logic              Clock;
	logic              resetn;
	logic              start;
	logic [DATA_W-1:0] read_data;
	sram_req_t         sram;
	logic              done;

	logic [15:0] src_words [YUV_WORDS]; // Y, U and V planes as loaded
	logic [31:0] rng_state;
	int          write_count;
	int          done_count;
	logic        done_prev;

	yuv2rgb_top #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT),
		.RGB_BASE   (RGB_BASE)
	) uut (
		.Clock     (Clock),
		.resetn    (resetn),
		.start     (start),
		.read_data (read_data),
		.sram      (sram),
		.done      (done)
	);

	sram_model #(.WORDS(MEM_WORDS)) mem_model (
		.Clock     (Clock),
		.req       (sram),
		.read_data (read_data)
	);

	initial Clock = 1'b0;
	always #2 Clock = ~Clock;

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("ERR at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [7:0] clamp_byte(input int x);
		if (x < 0)
			return 8'd0;
		if (x > 255)
			return 8'd255;
		return 8'(x);
	endfunction

	// edge samples repeat at both ends of the row
	function automatic int chroma_at(input int base, input int row, input int idx);
		int i;
		logic [15:0] w;
		i = idx;
		if (i < 0)
			i = 0;
		if (i > HALF_W - 1)
			i = HALF_W - 1;
		w = src_words[base + row * (IMG_WIDTH / 4) + i / 2];
		return (i % 2 == 0) ? int'(w[15:8]) : int'(w[7:0]);
	endfunction

	function automatic int odd_chroma(input int base, input int row, input int k);
		int acc;
		acc = 21 * (chroma_at(base, row, k - 2) + chroma_at(base, row, k + 3))
			- 52 * (chroma_at(base, row, k - 1) + chroma_at(base, row, k + 2))
			+ 159 * (chroma_at(base, row, k) + chroma_at(base, row, k + 1)) + 128;
		return int'(clamp_byte(acc >>> 8));
	endfunction

	function automatic logic [23:0] pixel_rgb(input int y, input int u, input int v);
		int luma;
		int r;
		int g;
		int b;
		luma = 76284 * (y - 16);
		r = (luma + 104595 * (v - 128)) >>> 16;
		g = (luma - 25624 * (u - 128) - 53281 * (v - 128)) >>> 16;
		b = (luma + 132251 * (u - 128)) >>> 16;
		return {clamp_byte(r), clamp_byte(g), clamp_byte(b)};
	endfunction

	function automatic logic [15:0] expected_word(input int row, input int k, input int j);
		logic [15:0] yw;
		logic [23:0] p0;
		logic [23:0] p1;
		yw = src_words[row * HALF_W + k];
		p0 = pixel_rgb(int'(yw[15:8]), chroma_at(U_BASE, row, k), chroma_at(V_BASE, row, k));
		p1 = pixel_rgb(int'(yw[7:0]), odd_chroma(U_BASE, row, k), odd_chroma(V_BASE, row, k));
		case (j)
		0: return p0[23:8];
		1: return {p0[7:0], p1[23:16]};
		default: return p1[15:0];
		endcase
	endfunction

	task automatic scrub_memory();
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem_model.mem[a] <= 16'(a) ^ 16'h5a5a;
		end
	endtask

	task automatic store_word(input int a, input logic [15:0] w);
		src_words[a] = w;
		mem_model.mem[a] <= w;
	endtask

	task automatic load_uniform(input logic [7:0] y, input logic [7:0] u, input logic [7:0] v);
		scrub_memory();
		for (int a = 0; a < YUV_WORDS; a++) begin
			store_word(a, (a < U_BASE) ? {y, y} : (a < V_BASE) ? {u, u} : {v, v});
		end
	endtask

	task automatic load_random();
		scrub_memory();
		for (int a = 0; a < YUV_WORDS; a++) begin
			rng_state = xorshift32(rng_state);
			store_word(a, rng_state[15:0]);
		end
	endtask

	task automatic compare_frame();
		int a;
		logic [15:0] got;
		logic [15:0] exp;
		for (int row = 0; row < IMG_HEIGHT; row++) begin
			for (int k = 0; k < HALF_W; k++) begin
				for (int j = 0; j < 3; j++) begin
					a = RGB_BASE + 3 * (row * HALF_W + k) + j;
					got = mem_model.mem[a];
					exp = expected_word(row, k, j);
					assert (got == exp)
					else report_mismatch($sformatf("row %0d pair %0d word %0d: got %h, expected %h",
						row, k, j, got, exp));
				end
			end
		end
	endtask

	task automatic run_frame();
		int cycles;
		@(posedge Clock);
		write_count = 0;
		done_count = 0;
		start <= 1'b1;
		@(posedge Clock);
		start <= 1'b0;
		cycles = 0;
		@(negedge Clock);
		while (!done) begin
			if (cycles == DONE_TIMEOUT) begin
				$display("Timeout: no done pulse within %0d cycles of start", DONE_TIMEOUT);
				abort_run();
			end
			@(negedge Clock);
			cycles++;
		end
		repeat (8) @(negedge Clock); // room for a stray done or write
		assert (done_count == 1)
		else report_mismatch($sformatf("done pulsed %0d times in one frame", done_count));
		assert (write_count == RGB_WORDS)
		else report_mismatch($sformatf("%0d writes, expected %0d", write_count, RGB_WORDS));
		compare_frame();
	endtask

	// write address and done pulse monitor
	always @(negedge Clock) begin
		if (resetn) begin
			if (!sram.we_n) begin
				assert (int'(sram.addr) == RGB_BASE + write_count)
				else report_mismatch($sformatf("write %0d went to address %0d",
					write_count, sram.addr));
				write_count++;
			end
			if (done) begin
				assert (!done_prev) else report_mismatch("done high for two cycles");
				done_count++;
			end
			done_prev = done;
		end
	end

	task automatic check_idle_outputs();
		repeat (20) begin
			@(negedge Clock);
			assert (sram.we_n === 1'b1 && done === 1'b0)
			else report_mismatch("we_n low or done high before start");
		end
	endtask

	task automatic grey_frame();
		logic [15:0] w;
		load_uniform(8'd128, 8'd128, 8'd128);
		run_frame();
		for (int a = RGB_BASE; a < RGB_BASE + RGB_WORDS; a++) begin
			w = mem_model.mem[a];
			assert (w == 16'h8282)
			else report_mismatch($sformatf("grey word at %0d is %h, expected 8282", a, w));
		end
	endtask

	task automatic random_frame();
		load_random();
		run_frame();
	endtask

	task automatic saturation_frames();
		logic [15:0] w0;
		logic [15:0] w1;
		load_uniform(8'd255, 8'd128, 8'd255);
		run_frame();
		for (int p = 0; p < HALF_W * IMG_HEIGHT; p++) begin
			w0 = mem_model.mem[RGB_BASE + 3 * p];
			w1 = mem_model.mem[RGB_BASE + 3 * p + 1];
			assert (w0[15:8] == 8'd255 && w1[7:0] == 8'd255)
			else report_mismatch($sformatf("pair %0d red not saturated: %h %h", p, w0, w1));
		end
		load_uniform(8'd0, 8'd128, 8'd128);
		run_frame();
		for (int a = RGB_BASE; a < RGB_BASE + RGB_WORDS; a++) begin
			w0 = mem_model.mem[a];
			assert (w0 == 16'h0000)
			else report_mismatch($sformatf("black word at %0d is %h", a, w0));
		end
	endtask

	task automatic second_frame_after_done();
		load_random();
		run_frame();
		load_random(); // new image, started right after done
		run_frame();
	endtask

	initial begin
		resetn = 1'b0;
		start = 1'b0;
		rng_state = 32'h2add;
		write_count = 0;
		done_count = 0;
		done_prev = 1'b0;
		repeat (3) @(posedge Clock);
		resetn <= 1'b1;
		check_idle_outputs();
		grey_frame();
		random_frame();
		saturation_frames();
		second_frame_after_done();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- yuv2rgb.f
design/yuv2rgb_pkg.sv
design/chroma_upsampler.sv
design/colour_matrix.sv
design/frame_sequencer.sv
design/yuv2rgb_top.sv
testbench/sram_model.sv
testbench/yuv2rgb_sva.sv
testbench/yuv2rgb_tb.sv
